//--- design/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // basic types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [2:0]  reg_idx_t;  // 8 registers.
  typedef logic [15:0] word_t;     // data word.

  // opcodes; anything past HALT decodes as a nop.
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_XOR  = 4'd2,
    OP_ANDN = 4'd3,   // rs & ~rt.
    OP_ADDI = 4'd4,
    OP_LD   = 4'd5,
    OP_ST   = 4'd6,
    OP_HALT = 4'd7
  } op_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction word, two views.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    op_e        op;     // [15:12].
    reg_idx_t   rd;     // [11:9].
    reg_idx_t   rs;     // [8:6].
    reg_idx_t   rt;     // [5:3].
    logic [2:0] funct;  // spare.
  } r_fmt_t;

  typedef struct packed {
    op_e        op;
    reg_idx_t   rd;
    reg_idx_t   rs;
    logic [5:0] imm6;   // signed offset.
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } inst_u;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stage and bus structs.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic     reg_write;
    logic     mem_read;   // also selects memory data at write-back.
    logic     mem_write;
    logic     halt;
    reg_idx_t dst_reg;    // zero when nothing is written.
  } ex_ctrl_t;

  typedef struct packed {
    logic     valid;
    ex_ctrl_t ctrl;
    word_t    data_out;   // alu result or address.
    word_t    data_two;   // store data.
    reg_idx_t rd;         // raw rd field.
  } ex_mem_t;

  typedef struct packed {
    logic  req;     // one cycle pulse.
    logic  wr;
    word_t index;   // word index inside the bank.
    word_t wdata;
  } bank_req_t;

  typedef struct packed {
    logic  done;    // one cycle pulse.
    word_t rdata;
  } bank_rsp_t;

  typedef struct packed {
    logic     valid;
    logic     reg_write;
    reg_idx_t rd;
    word_t    data;
  } wb_t;

endpackage

`default_nettype wire

//--- design/alu_exec.sv
`timescale 1ns/1ns
`default_nettype none

module alu_exec (
  input  wire                     valid_i,
  input  wire mem_stage_pkg::inst_u instruction_i,
  input  wire mem_stage_pkg::word_t data_one_i,     // rs value.
  input  wire mem_stage_pkg::word_t data_two_i,     // rt value.
  output mem_stage_pkg::ex_mem_t  exec_o
);

  mem_stage_pkg::word_t imm_sext;

  // sign extend the 6 bit offset.
  assign imm_sext = {{10{instruction_i.i_fmt.imm6[5]}}, instruction_i.i_fmt.imm6};

  always_comb begin
    exec_o = '0;                              // bubble when nothing issues.
    if (valid_i) begin
      exec_o.valid    = 1'b1;
      exec_o.data_two = data_two_i;           // only a store uses it.
      exec_o.rd       = instruction_i.r_fmt.rd;
      case (instruction_i.r_fmt.op)
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // r format, rd = rs op rt.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        mem_stage_pkg::OP_ADD: begin
          exec_o.data_out       = data_one_i + data_two_i;
          exec_o.ctrl.reg_write = 1'b1;
        end
        mem_stage_pkg::OP_SUB: begin
          exec_o.data_out       = data_one_i - data_two_i;
          exec_o.ctrl.reg_write = 1'b1;
        end
        mem_stage_pkg::OP_XOR: begin
          exec_o.data_out       = data_one_i ^ data_two_i;
          exec_o.ctrl.reg_write = 1'b1;
        end
        mem_stage_pkg::OP_ANDN: begin
          exec_o.data_out       = data_one_i & ~data_two_i;
          exec_o.ctrl.reg_write = 1'b1;
        end
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // i format, rs + imm.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        mem_stage_pkg::OP_ADDI: begin
          exec_o.data_out       = data_one_i + imm_sext;
          exec_o.ctrl.reg_write = 1'b1;
        end
        mem_stage_pkg::OP_LD: begin
          exec_o.data_out       = data_one_i + imm_sext;    // address.
          exec_o.ctrl.reg_write = 1'b1;
          exec_o.ctrl.mem_read  = 1'b1;
        end
        mem_stage_pkg::OP_ST: begin
          exec_o.data_out       = data_one_i + imm_sext;
          exec_o.ctrl.mem_write = 1'b1;
        end
        mem_stage_pkg::OP_HALT: exec_o.ctrl.halt = 1'b1;
        default: ;                            // nop, valid with no write.
      endcase
      // destination only for writing ops.
      if (exec_o.ctrl.reg_write) exec_o.ctrl.dst_reg = instruction_i.i_fmt.rd;
    end
  end

endmodule

`default_nettype wire

//--- design/ex_mem_reg.sv
`timescale 1ns/1ns
`default_nettype none

module ex_mem_reg (
  input  wire                       clk_i,
  input  wire                       arst_n_i,
  input  wire mem_stage_pkg::ex_mem_t stage_i,   // zero when nothing issued.
  input  wire                       hold_i,    // inst stall or data stall.
  output mem_stage_pkg::ex_mem_t    stage_o
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next state mux.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  mem_stage_pkg::ex_mem_t stage_d;
  mem_stage_pkg::ex_mem_t stage_q;

  // whole struct loops back on a stall.
  // control and payload move together.
  assign stage_d = hold_i ? stage_q : stage_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // the register.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stage_q <= '0;          // empty stage, no mem op pending.
    end else begin
      stage_q <= stage_d;     // bubble enters when stage_i is zero.
    end
  end

  assign stage_o = stage_q;

endmodule

`default_nettype wire

//--- design/bank_router.sv
`timescale 1ns/1ns
`default_nettype none

module bank_router #(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_DEPTH = 16
) (
  input  wire                                          clk_i,
  input  wire                                          arst_n_i,
  input  wire mem_stage_pkg::ex_mem_t                  stage_i,
  input  wire                                          done_i,     // d_done.
  output mem_stage_pkg::bank_req_t [NUM_BANKS-1:0]     bank_req_o,
  output logic                                         d_stall_o
);

  localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  logic                 mem_op;
  logic                 issue;
  logic                 issued_q;   // request sent, waiting for done.
  logic [BANK_W-1:0]    bank_sel;
  mem_stage_pkg::word_t bank_idx;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address split, low bits pick the bank.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign bank_sel = BANK_W'(stage_i.data_out % NUM_BANKS);
  assign bank_idx = mem_stage_pkg::word_t'((stage_i.data_out / NUM_BANKS) % BANK_DEPTH);

  assign mem_op    = stage_i.valid & (stage_i.ctrl.mem_read | stage_i.ctrl.mem_write);
  assign issue     = mem_op & ~issued_q & ~done_i;   // once per op.
  assign d_stall_o = mem_op & ~done_i;               // reference condition.

  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_req_o[b].req   = issue & (bank_sel == BANK_W'(b));
      bank_req_o[b].wr    = stage_i.ctrl.mem_write;  // broadcast, req qualifies.
      bank_req_o[b].index = bank_idx;
      bank_req_o[b].wdata = stage_i.data_two;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      issued_q <= 1'b0;
    end else if (done_i) begin
      issued_q <= 1'b0;       // op finished.
    end else if (issue) begin
      issued_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/dmem_bank.sv
`timescale 1ns/1ns
`default_nettype none

module dmem_bank #(
  parameter int BANK_DEPTH  = 16,
  parameter int MEM_LATENCY = 3
) (
  input  wire                          clk_i,
  input  wire                          arst_n_i,
  input  wire mem_stage_pkg::bank_req_t req_i,
  output mem_stage_pkg::bank_rsp_t     rsp_o
);

  localparam int IDX_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;
  localparam int CNT_W = $clog2(MEM_LATENCY + 1);

  mem_stage_pkg::word_t     mem_q [BANK_DEPTH];
  mem_stage_pkg::bank_rsp_t rsp_q;
  logic                     busy_q;
  logic [CNT_W-1:0]         cnt_q;     // cycles left.
  logic                     wr_q;
  logic [IDX_W-1:0]         idx_q;
  mem_stage_pkg::word_t     wdata_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request capture.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (req_i.req && !busy_q) begin
      wr_q    <= req_i.wr;
      idx_q   <= req_i.index[IDX_W-1:0];   // upper bits dropped.
      wdata_q <= req_i.wdata;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // latency countdown and array access.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      rsp_q  <= '0;
      for (int i = 0; i < BANK_DEPTH; i++) begin
        mem_q[i] <= '0;         // banks come up zeroed.
      end
    end else begin
      rsp_q.done <= 1'b0;       // pulse.
      if (busy_q) begin
        if (cnt_q == '0) begin
          busy_q     <= 1'b0;
          rsp_q.done <= 1'b1;
          if (wr_q) begin
            mem_q[idx_q] <= wdata_q;
          end else begin
            rsp_q.rdata <= mem_q[idx_q];
          end
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end else if (req_i.req) begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(MEM_LATENCY - 1);   // done lands MEM_LATENCY later.
      end
    end
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

//--- design/bank_collector.sv
`timescale 1ns/1ns
`default_nettype none

module bank_collector #(
  parameter int NUM_BANKS = 4
) (
  input  wire                                            clk_i,
  input  wire                                            arst_n_i,
  input  wire mem_stage_pkg::ex_mem_t                    stage_i,
  input  wire                                            hold_i,
  input  wire mem_stage_pkg::bank_rsp_t [NUM_BANKS-1:0]  rsp_i,
  output logic                                           done_o,
  output mem_stage_pkg::wb_t                             wb_o,
  output logic                                           halt_o
);

  logic                 rsp_done;
  mem_stage_pkg::word_t rsp_data;
  logic                 done_held_q;   // finished op still held in EX/MEM.
  logic                 alu_fire;
  logic                 wb_fire;
  mem_stage_pkg::wb_t   wb_q;
  logic                 halt_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response merge, one bank busy at most.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rsp_done = 1'b0;
    rsp_data = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      rsp_done = rsp_done | rsp_i[b].done;
      rsp_data = rsp_data | (rsp_i[b].done ? rsp_i[b].rdata : '0);
    end
  end

  // done stays up while a front-end stall keeps the op in place.
  assign done_o = rsp_done | done_held_q;

  assign alu_fire = stage_i.valid & ~hold_i &
                    ~(stage_i.ctrl.mem_read | stage_i.ctrl.mem_write);
  assign wb_fire  = alu_fire | rsp_done;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_held_q <= 1'b0;
      wb_q        <= '0;
      halt_q      <= 1'b0;
    end else begin
      done_held_q <= done_o & hold_i;
      wb_q.valid  <= wb_fire;
      if (wb_fire) begin
        wb_q.reg_write <= stage_i.ctrl.reg_write;
        // raw rd field, the destination when writing.
        wb_q.rd   <= stage_i.rd;
        wb_q.data <= stage_i.ctrl.mem_read ? rsp_data : stage_i.data_out;
      end
      if (alu_fire && stage_i.ctrl.halt) halt_q <= 1'b1;   // sticky.
    end
  end

  assign wb_o   = wb_q;
  assign halt_o = halt_q;

endmodule

`default_nettype wire

//--- design/mem_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top #(
  parameter int NUM_BANKS   = 4,    // power of two.
  parameter int BANK_DEPTH  = 16,
  parameter int MEM_LATENCY = 3     // at least 1.
) (
  input  wire                       clk_i,
  input  wire                       arst_n_i,
  input  wire                       valid_i,
  input  wire mem_stage_pkg::inst_u instruction_i,
  input  wire mem_stage_pkg::word_t data_one_i,
  input  wire mem_stage_pkg::word_t data_two_i,
  input  wire                       inst_stall_i,
  output logic                      stall_o,
  output mem_stage_pkg::wb_t        wb_o,
  output logic                      halt_o
);

  wire mem_stage_pkg::ex_mem_t                   exec_stage;
  wire mem_stage_pkg::ex_mem_t                   mem_stage;
  wire mem_stage_pkg::bank_req_t [NUM_BANKS-1:0] bank_req;
  wire mem_stage_pkg::bank_rsp_t [NUM_BANKS-1:0] bank_rsp;
  wire                                           d_done;
  wire                                           d_stall;
  wire                                           hold;

  assign hold    = inst_stall_i | d_stall;   // freezes EX/MEM.
  assign stall_o = d_stall;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // execute and EX/MEM.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  alu_exec u_alu_exec (
    .valid_i       (valid_i),
    .instruction_i (instruction_i),
    .data_one_i    (data_one_i),
    .data_two_i    (data_two_i),
    .exec_o        (exec_stage)
  );

  ex_mem_reg u_ex_mem_reg (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .stage_i  (exec_stage),
    .hold_i   (hold),
    .stage_o  (mem_stage)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory side.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  bank_router #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH)
  ) u_bank_router (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .stage_i    (mem_stage),
    .done_i     (d_done),
    .bank_req_o (bank_req),
    .d_stall_o  (d_stall)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    dmem_bank #(
      .BANK_DEPTH  (BANK_DEPTH),
      .MEM_LATENCY (MEM_LATENCY)
    ) u_dmem_bank (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .req_i    (bank_req[b]),
      .rsp_o    (bank_rsp[b])
    );
  end

  bank_collector #(
    .NUM_BANKS (NUM_BANKS)
  ) u_bank_collector (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .stage_i  (mem_stage),
    .hold_i   (hold),
    .rsp_i    (bank_rsp),
    .done_o   (d_done),
    .wb_o     (wb_o),
    .halt_o   (halt_o)
  );

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released on a falling edge, away from the flops.
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker #(
  parameter int NUM_BANKS   = 4,
  parameter int BANK_DEPTH  = 16,
  parameter int MEM_LATENCY = 3
) (
  input  wire                       clk_i,
  input  wire                       arst_n_i,
  input  wire                       valid_i,
  input  wire mem_stage_pkg::inst_u instruction_i,
  input  wire mem_stage_pkg::word_t data_one_i,
  input  wire mem_stage_pkg::word_t data_two_i,
  input  wire                       inst_stall_i,
  input  wire                       stall_i,      // dut stall_o.
  input  wire mem_stage_pkg::wb_t   wb_i,
  input  wire                       halt_i,
  output int                        errors_o,
  output int                        pending_o     // ops not yet written back.
);

  typedef struct packed {
    logic               is_mem;
    logic               is_halt;
    int                 cycle;     // falling edge count at acceptance.
    mem_stage_pkg::wb_t wb;
  } exp_t;

  exp_t                 exp_q[$];
  mem_stage_pkg::word_t model_mem [NUM_BANKS][BANK_DEPTH];
  int                   cycle;
  logic                 halt_seen;
  logic                 alu_due;   // non-mem op leaves EX/MEM at the next edge.

  task automatic flag_mismatch(input string what);
    errors_o++;
    $display("[ERROR] %0t ns: %s", $time, what);
  endtask

  task automatic flag_fault(input string what);
    errors_o++;
    $display("%s, at %0t ns", what, $time);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // everything sampled mid cycle, where the dut is settled.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk_i) begin : watch
    exp_t                 head;
    exp_t                 e;
    int                   lat;
    int                   bank;
    int                   idx;
    mem_stage_pkg::word_t imm;
    mem_stage_pkg::word_t addr;
    if (!arst_n_i) begin
      exp_q.delete();
      cycle     = 0;
      halt_seen = 1'b0;
      alu_due   = 1'b0;
      errors_o  = 0;
      for (int b = 0; b < NUM_BANKS; b++) begin
        for (int i = 0; i < BANK_DEPTH; i++) begin
          model_mem[b][i] = '0;             // banks come up zeroed.
        end
      end
    end else begin
      cycle++;
      if (cycle == 1 && (stall_i || wb_i.valid || halt_i)) begin
        flag_fault("stall, write-back or halt was not low after reset");
      end
      // in order compare of the write-back.
      if (wb_i.valid) begin
        if (exp_q.size() == 0) begin
          flag_fault("a write-back came out with no operation outstanding");
        end else begin
          head = exp_q.pop_front();
          lat  = cycle - head.cycle;
          if (wb_i.reg_write !== head.wb.reg_write) begin
            flag_mismatch($sformatf("reg_write %0b, expected %0b",
                                    wb_i.reg_write, head.wb.reg_write));
          end
          if (wb_i.rd !== head.wb.rd) begin
            flag_mismatch($sformatf("rd %0d, expected %0d", wb_i.rd, head.wb.rd));
          end
          if (head.wb.reg_write && wb_i.data !== head.wb.data) begin
            flag_mismatch($sformatf("data %h, expected %h", wb_i.data, head.wb.data));
          end
          if (head.is_mem && lat != MEM_LATENCY + 3) begin
            flag_mismatch($sformatf("memory op latency %0d, expected %0d",
                                    lat, MEM_LATENCY + 3));
          end
          if (head.is_halt) halt_seen = 1'b1;
        end
      end else if (alu_due) begin
        flag_fault("a non-memory op was not written back after leaving EX/MEM");
      end
      alu_due = 1'b0;
      if (halt_i !== halt_seen) begin
        flag_mismatch($sformatf("halt_o %0b, expected %0b", halt_i, halt_seen));
      end
      // oldest op is the one sitting in EX/MEM.
      if (exp_q.size() != 0 && exp_q[0].cycle < cycle) begin
        if (exp_q[0].is_mem) begin
          // stall drops only in the done cycle.
          if (stall_i !== (cycle != exp_q[0].cycle + MEM_LATENCY + 2)) begin
            flag_mismatch($sformatf("stall_o %0b during a memory op", stall_i));
          end
        end else begin
          alu_due = !inst_stall_i;
        end
      end
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // accepted op, expected result from the isa rules.
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      if (valid_i && !inst_stall_i && !stall_i) begin
        e    = '0;
        imm  = {{10{instruction_i.i_fmt.imm6[5]}}, instruction_i.i_fmt.imm6};
        addr = data_one_i + imm;
        bank = int'(addr % NUM_BANKS);                 // low bits pick the bank.
        idx  = int'((addr / NUM_BANKS) % BANK_DEPTH);
        e.cycle    = cycle;
        e.wb.valid = 1'b1;
        e.wb.rd    = instruction_i.r_fmt.rd;
        case (instruction_i.r_fmt.op)
          mem_stage_pkg::OP_ADD: begin
            e.wb.reg_write = 1'b1;
            e.wb.data      = data_one_i + data_two_i;
          end
          mem_stage_pkg::OP_SUB: begin
            e.wb.reg_write = 1'b1;
            e.wb.data      = data_one_i - data_two_i;
          end
          mem_stage_pkg::OP_XOR: begin
            e.wb.reg_write = 1'b1;
            e.wb.data      = data_one_i ^ data_two_i;
          end
          mem_stage_pkg::OP_ANDN: begin
            e.wb.reg_write = 1'b1;
            e.wb.data      = data_one_i & ~data_two_i;
          end
          mem_stage_pkg::OP_ADDI: begin
            e.wb.reg_write = 1'b1;
            e.wb.data      = addr;                     // rs + imm.
          end
          mem_stage_pkg::OP_LD: begin
            e.is_mem       = 1'b1;
            e.wb.reg_write = 1'b1;
            e.wb.data      = model_mem[bank][idx];
          end
          mem_stage_pkg::OP_ST: begin
            e.is_mem              = 1'b1;
            model_mem[bank][idx] = data_two_i;   // ops retire in order.
          end
          mem_stage_pkg::OP_HALT: e.is_halt = 1'b1;
          default: ;                              // nop, nothing written.
        endcase
        exp_q.push_back(e);
      end
    end
    pending_o = exp_q.size();
  end

endmodule

`default_nettype wire

//--- bench/tb_mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsys;

  localparam int NUM_BANKS    = 4;
  localparam int BANK_DEPTH   = 16;
  localparam int MEM_LATENCY  = 3;
  localparam int CLK_NS       = 8;
  localparam int OPS_PER_TEST = 40;
  localparam int NUM_TESTS    = 6;
  // worst op is a memory op plus a two cycle front-end stall.
  localparam int WATCHDOG_NS  = NUM_TESTS * OPS_PER_TEST * (MEM_LATENCY + 4) * CLK_NS + 2000;

  localparam int MODE_ALU    = 0;
  localparam int MODE_MEM    = 1;
  localparam int MODE_MIX    = 2;
  localparam int MODE_ISTALL = 3;
  localparam int MODE_NOP    = 4;
  localparam int MODE_HALT   = 5;

  logic                 clk;
  logic                 arst_n;
  logic                 valid;
  mem_stage_pkg::inst_u instr;
  mem_stage_pkg::word_t data_one;
  mem_stage_pkg::word_t data_two;
  logic                 inst_stall;
  logic                 stall;
  mem_stage_pkg::wb_t   wb;
  logic                 halt;
  int                   errors;
  int                   pending;
  logic [15:0]          lfsr_q;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_NS),
    .RESET_CYCLES (5)
  ) u_clock_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  mem_subsys_top #(
    .NUM_BANKS   (NUM_BANKS),
    .BANK_DEPTH  (BANK_DEPTH),
    .MEM_LATENCY (MEM_LATENCY)
  ) i_dut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .valid_i       (valid),
    .instruction_i (instr),
    .data_one_i    (data_one),
    .data_two_i    (data_two),
    .inst_stall_i  (inst_stall),
    .stall_o       (stall),
    .wb_o          (wb),
    .halt_o        (halt)
  );

  tb_checker #(
    .NUM_BANKS   (NUM_BANKS),
    .BANK_DEPTH  (BANK_DEPTH),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_checker (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .valid_i       (valid),
    .instruction_i (instr),
    .data_one_i    (data_one),
    .data_two_i    (data_two),
    .inst_stall_i  (inst_stall),
    .stall_i       (stall),
    .wb_i          (wb),
    .halt_i        (halt),
    .errors_o      (errors),
    .pending_o     (pending)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one step per bit taken.
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v      = {v[14:0], lfsr_q[15]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  task automatic make_op(input int mode, input int idx, output mem_stage_pkg::inst_u ins,
                         output mem_stage_pkg::word_t a, output mem_stage_pkg::word_t b);
    logic [3:0]  op;
    logic [15:0] bits;
    case (mode)
      MODE_ALU:  op = 4'(take_bits(3) % 16'd5);       // add .. addi.
      MODE_MEM:  op = (idx < 12 || take_bits(2) == 16'd0) ? mem_stage_pkg::OP_ST
                                                           : mem_stage_pkg::OP_LD;
      MODE_NOP:  op = 4'(16'd8 + take_bits(3));
      MODE_HALT: op = (idx == 10) ? mem_stage_pkg::OP_HALT : 4'(take_bits(3) % 16'd5);
      default: begin
        op = 4'(take_bits(3));
        if (op == 4'd7) op = 4'hf;                   // halt kept for its own test.
      end
    endcase
    bits = take_bits(12);
    ins  = {op, bits[11:0]};
    if (op == mem_stage_pkg::OP_LD || op == mem_stage_pkg::OP_ST) begin
      bits = take_bits(6);
      a    = {10'd0, bits[5:0]};                     // small base, so loads hit.
    end else begin
      a = take_bits(16);
    end
    b = take_bits(16);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // issue one test worth of ops, then drain.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_test(input int mode, input string name);
    mem_stage_pkg::inst_u ins;
    mem_stage_pkg::word_t a;
    mem_stage_pkg::word_t b;
    int                   err_start;
    int                   gap;
    err_start = errors;
    for (int i = 0; i < OPS_PER_TEST; i++) begin
      make_op(mode, i, ins, a, b);
      if (mode == MODE_ISTALL && take_bits(2) == 16'd0) begin
        gap = 1 + int'(take_bits(1));
        repeat (gap) begin
          @(posedge clk);
          valid      <= 1'b0;                        // nothing issues under a stall.
          inst_stall <= 1'b1;
        end
      end
      @(posedge clk);
      valid      <= 1'b1;
      instr      <= ins;
      data_one   <= a;
      data_two   <= b;
      inst_stall <= 1'b0;
      // held until a falling edge sees stall_o low.
      do @(negedge clk); while (stall);
    end
    @(posedge clk);
    valid <= 1'b0;
    while (pending != 0) @(posedge clk);
    repeat (2) @(posedge clk);                       // catch a stray write-back.
    $display("test %-8s %0d ops, %0d errors, %s", name, OPS_PER_TEST,
             errors - err_start, (errors == err_start) ? "ok" : "FAIL");
  endtask

  initial begin
    valid      = 1'b0;
    instr      = '0;
    data_one   = '0;
    data_two   = '0;
    inst_stall = 1'b0;
    lfsr_q     = 16'd52;
    @(posedge arst_n);
    @(posedge clk);
    run_test(MODE_ALU,    "alu");
    run_test(MODE_MEM,    "st_ld");
    run_test(MODE_MIX,    "mixed");
    run_test(MODE_ISTALL, "istall");
    run_test(MODE_NOP,    "nop");
    run_test(MODE_HALT,   "halt");
    $display("tests %0d, ops %0d, errors %0d", NUM_TESTS, NUM_TESTS * OPS_PER_TEST, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog.
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- mem_subsys_top.f
design/mem_stage_pkg.sv
design/alu_exec.sv
design/ex_mem_reg.sv
design/bank_router.sv
design/dmem_bank.sv
design/bank_collector.sv
design/mem_subsys_top.sv
bench/tb_clock_gen.sv
bench/tb_checker.sv
bench/tb_mem_subsys.sv

//--- Makefile
SIM        := verilator
TOP        := tb_mem_subsys
FILELIST   := mem_subsys_top.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
LOG        := sim.log
PASS_MSG   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
